// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary -j 0 -f src.f --top-module gfx_demo_tb -o gfx_demo_sim
	./obj_dir/gfx_demo_sim

clean:
	rm -rf obj_dir

// ==== hdl/delay.sv ====
`timescale 1ns/1ns

module delay #(
  parameter int delay_cycles = 8
) (
  input  logic clk,
  input  logic rst_n,
  input  logic in,
  output logic out
);

  logic [delay_cycles-1:0] sr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sr <= '0;
    end else begin
      sr[0] <= in;
      for (int i = 1; i < delay_cycles; i++) begin
        sr[i] <= sr[i-1];
      end
    end
  end

  assign out = sr[delay_cycles-1];  // oldest stage.

endmodule

// ==== hdl/gfx_demo.sv ====
`timescale 1ns/1ns

module gfx_demo import gfx_pkg::*; #(
  parameter int vga_width    = 640,
  parameter int vga_height   = 480,
  parameter int h_front      = 16,
  parameter int h_sync       = 96,
  parameter int h_back       = 48,
  parameter int v_front      = 10,
  parameter int v_sync       = 2,
  parameter int v_back       = 33,
  parameter int delay_cycles = 8
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     draw,
  input  pixel_t   seed,
  output vga_out_t vga,
  output logic     busy
);

  fb_write_t gfx_wr;
  logic      gfx_valid;
  logic      gfx_ready;
  logic      gfx_inc;
  logic      vga_enable;

  gfx_test_pattern #(
    .vga_width (vga_width),
    .vga_height(vga_height)
  ) gfx_inst (
    .clk  (clk),
    .rst_n(rst_n),
    .draw (draw),
    .seed (seed),
    .inc  (gfx_inc),
    .wr   (gfx_wr),
    .valid(gfx_valid),
    .last ()  // consumed inside the drawer.
  );

  assign gfx_inc = gfx_valid & gfx_ready;
  assign busy    = gfx_valid;

  gfx_vga #(
    .vga_width (vga_width),
    .vga_height(vga_height),
    .h_front   (h_front),
    .h_sync    (h_sync),
    .h_back    (h_back),
    .v_front   (v_front),
    .v_sync    (v_sync),
    .v_back    (v_back)
  ) gfx_vga_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .enable(vga_enable),
    .wr    (gfx_wr),
    .valid (gfx_valid),
    .ready (gfx_ready),
    .vga   (vga)
  );

  // hold scanout off briefly so the drawer gets a head start.
  delay #(
    .delay_cycles(delay_cycles)
  ) vga_fb_delay (
    .clk  (clk),
    .rst_n(rst_n),
    .in   (1'b1),
    .out  (vga_enable)
  );

endmodule

// ==== hdl/gfx_fb.sv ====
`timescale 1ns/1ns

module gfx_fb import gfx_pkg::*; #(
  parameter int vga_width  = 640,
  parameter int vga_height = 480
) (
  input  logic              clk,
  input  logic              rd_en,
  input  logic [x_bits-1:0] rd_x,
  input  logic [y_bits-1:0] rd_y,
  output pixel_t            rd_data,
  input  fb_write_t         wr,
  input  logic              wr_en
);

  localparam int depth     = vga_width * vga_height;
  localparam int addr_bits = $clog2(depth);

  pixel_t               mem [depth];
  logic [addr_bits-1:0] rd_addr;
  logic [addr_bits-1:0] wr_addr;
  logic [addr_bits-1:0] addr;

  // row-major index.
  assign rd_addr = addr_bits'(rd_y * vga_width + rd_x);
  assign wr_addr = addr_bits'(wr.y * vga_width + wr.x);

  // one port, scanout owns it when reading.
  assign addr = rd_en ? rd_addr : wr_addr;

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[addr];
    end else if (wr_en) begin
      mem[addr] <= wr.color;
    end
  end

endmodule

// ==== hdl/gfx_pkg.sv ====
package gfx_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int color_bits = 4;  // per channel.
  localparam int x_bits = 10;
  localparam int y_bits = 9;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bundles
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic [color_bits-1:0] red;
    logic [color_bits-1:0] grn;
    logic [color_bits-1:0] blu;
  } pixel_t;

  // one pixel write from the drawer.
  typedef struct packed {
    logic [x_bits-1:0] x;
    logic [y_bits-1:0] y;
    pixel_t            color;
  } fb_write_t;

  // pin bundle, syncs active low.
  typedef struct packed {
    logic [color_bits-1:0] red;
    logic [color_bits-1:0] grn;
    logic [color_bits-1:0] blu;
    logic                  hsync;
    logic                  vsync;
  } vga_out_t;

endpackage

// ==== hdl/gfx_test_pattern.sv ====
`timescale 1ns/1ns

module gfx_test_pattern import gfx_pkg::*; #(
  parameter int vga_width  = 640,
  parameter int vga_height = 480
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      draw,
  input  pixel_t    seed,
  input  logic      inc,
  output fb_write_t wr,
  output logic      valid,
  output logic      last
);

  localparam logic [x_bits-1:0] x_last = x_bits'(vga_width - 1);
  localparam logic [y_bits-1:0] y_last = y_bits'(vga_height - 1);

  logic [x_bits-1:0]     x_cnt;
  logic [y_bits-1:0]     y_cnt;
  pixel_t                seed_q;
  pixel_t                color;
  logic [color_bits-1:0] xy_sum;
  logic                  start;

  assign start = draw && !valid;  // draws while busy are dropped.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // raster walk
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid <= 1'b0;
      x_cnt <= '0;
      y_cnt <= '0;
    end else if (start) begin
      valid <= 1'b1;
      x_cnt <= '0;
      y_cnt <= '0;
    end else if (valid && inc) begin
      if (last) begin
        valid <= 1'b0;
      end else if (x_cnt == x_last) begin
        x_cnt <= '0;
        y_cnt <= y_cnt + 1'b1;
      end else begin
        x_cnt <= x_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) seed_q <= seed;
  end

  assign last = valid && (x_cnt == x_last) && (y_cnt == y_last);

  // pattern from the low coordinate bits.
  assign xy_sum    = x_cnt[color_bits-1:0] + y_cnt[color_bits-1:0];
  assign color.red = x_cnt[color_bits-1:0] ^ seed_q.red;
  assign color.grn = y_cnt[color_bits-1:0] ^ seed_q.grn;
  assign color.blu = xy_sum ^ seed_q.blu;

  assign wr = '{x: x_cnt, y: y_cnt, color: color};

endmodule

// ==== hdl/gfx_vga.sv ====
`timescale 1ns/1ns

module gfx_vga import gfx_pkg::*; #(
  parameter int vga_width  = 640,
  parameter int vga_height = 480,
  parameter int h_front    = 16,
  parameter int h_sync     = 96,
  parameter int h_back     = 48,
  parameter int v_front    = 10,
  parameter int v_sync     = 2,
  parameter int v_back     = 33
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      enable,
  input  fb_write_t wr,
  input  logic      valid,
  output logic      ready,
  output vga_out_t  vga
);

  logic [x_bits-1:0] h;
  logic [y_bits-1:0] v;
  logic              active;
  logic              hsync;
  logic              vsync;
  logic              wr_en;
  pixel_t            rd_data;
  logic              active_d;
  logic              hsync_d;
  logic              vsync_d;
  pixel_t            pix;

  vga_timing #(
    .vga_width (vga_width),
    .vga_height(vga_height),
    .h_front   (h_front),
    .h_sync    (h_sync),
    .h_back    (h_back),
    .v_front   (v_front),
    .v_sync    (v_sync),
    .v_back    (v_back)
  ) timing_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .enable(enable),
    .h     (h),
    .v     (v),
    .active(active),
    .hsync (hsync),
    .vsync (vsync)
  );

  // drawer only gets the port outside the visible area.
  assign ready = !active;
  assign wr_en = valid && !active;

  gfx_fb #(
    .vga_width (vga_width),
    .vga_height(vga_height)
  ) fb_inst (
    .clk    (clk),
    .rd_en  (active),
    .rd_x   (h),
    .rd_y   (v),
    .rd_data(rd_data),
    .wr     (wr),
    .wr_en  (wr_en)
  );

  // match the memory read latency.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active_d <= 1'b0;
      hsync_d  <= 1'b1;
      vsync_d  <= 1'b1;
    end else begin
      active_d <= active;
      hsync_d  <= hsync;
      vsync_d  <= vsync;
    end
  end

  assign pix = active_d ? rd_data : '0;  // blank outside active.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vga <= '{red: '0, grn: '0, blu: '0, hsync: 1'b1, vsync: 1'b1};
    end else begin
      vga <= '{red: pix.red, grn: pix.grn, blu: pix.blu, hsync: hsync_d, vsync: vsync_d};
    end
  end

endmodule

// ==== hdl/vga_timing.sv ====
`timescale 1ns/1ns

module vga_timing import gfx_pkg::*; #(
  parameter int vga_width  = 640,
  parameter int vga_height = 480,
  parameter int h_front    = 16,
  parameter int h_sync     = 96,
  parameter int h_back     = 48,
  parameter int v_front    = 10,
  parameter int v_sync     = 2,
  parameter int v_back     = 33
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable,
  output logic [x_bits-1:0] h,
  output logic [y_bits-1:0] v,
  output logic              active,
  output logic              hsync,
  output logic              vsync
);

  localparam int h_total = vga_width + h_front + h_sync + h_back;
  localparam int v_total = vga_height + v_front + v_sync + v_back;
  localparam int h_bits  = $clog2(h_total);
  localparam int v_bits  = $clog2(v_total);

  localparam logic [h_bits-1:0] h_last     = h_bits'(h_total - 1);
  localparam logic [h_bits-1:0] h_act_end  = h_bits'(vga_width);
  localparam logic [h_bits-1:0] h_sync_beg = h_bits'(vga_width + h_front);
  localparam logic [h_bits-1:0] h_sync_end = h_bits'(vga_width + h_front + h_sync);

  localparam logic [v_bits-1:0] v_last     = v_bits'(v_total - 1);
  localparam logic [v_bits-1:0] v_act_end  = v_bits'(vga_height);
  localparam logic [v_bits-1:0] v_sync_beg = v_bits'(vga_height + v_front);
  localparam logic [v_bits-1:0] v_sync_end = v_bits'(vga_height + v_front + v_sync);

  logic [h_bits-1:0] h_cnt;
  logic [v_bits-1:0] v_cnt;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // counters
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!rst_n || !enable) begin
      h_cnt <= '0;  // parked at origin.
      v_cnt <= '0;
    end else if (h_cnt == h_last) begin
      h_cnt <= '0;
      if (v_cnt == v_last) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + 1'b1;
      end
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // active region first, then front porch, sync, back porch.
  assign active = enable && (h_cnt < h_act_end) && (v_cnt < v_act_end);
  assign hsync  = !((h_cnt >= h_sync_beg) && (h_cnt < h_sync_end));
  assign vsync  = !((v_cnt >= v_sync_beg) && (v_cnt < v_sync_end));

  assign h = x_bits'(h_cnt);  // only meaningful while active.
  assign v = y_bits'(v_cnt);

endmodule

// ==== src.f ====
hdl/gfx_pkg.sv
hdl/delay.sv
hdl/gfx_test_pattern.sv
hdl/gfx_fb.sv
hdl/vga_timing.sv
hdl/gfx_vga.sv
hdl/gfx_demo.sv
testbench/gfx_demo_tb.sv

// ==== testbench/gfx_demo_tb.sv ====
`timescale 1ns/1ns

module gfx_demo_tb import gfx_pkg::*; ();

  localparam int width        = 16;
  localparam int height       = 12;
  localparam int h_front      = 2;
  localparam int h_sync       = 3;
  localparam int h_back       = 3;
  localparam int v_front      = 1;
  localparam int v_sync       = 2;
  localparam int v_back       = 1;
  localparam int delay_cycles = 8;
  localparam int h_total      = width + h_front + h_sync + h_back;
  localparam int v_total      = height + v_front + v_sync + v_back;
  localparam int frame_cycles = h_total * v_total;
  localparam int n_draws      = 6;

  // one scan position as it travels to the pins.
  typedef struct packed {
    logic   act;
    logic   hs;
    logic   vs;
    logic   known;  // pixel drawn at least once.
    pixel_t pix;
  } stage_t;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     draw;
  pixel_t   seed;
  vga_out_t vga;
  logic     busy;

  pixel_t   model_mem [height][width];
  bit       written [height][width];
  logic     rst_seen = 1'b0;
  int       since_rst;
  int       mh;
  int       mv;
  logic     en;
  logic     en_prev;
  logic     busy_m;
  int       writes_m;
  pixel_t   seed_m;
  logic     prev_draw;
  logic     prev_act;
  logic     prev_busy;
  pixel_t   prev_seed;
  stage_t   cur;
  stage_t   p1;
  stage_t   p2;
  vga_out_t exp_vga;
  pixel_t   got_pix;
  int       wx;
  int       wy;
  int       cycles;
  int       limit = 1000000;

  gfx_demo #(
    .vga_width   (width),
    .vga_height  (height),
    .h_front     (h_front),
    .h_sync      (h_sync),
    .h_back      (h_back),
    .v_front     (v_front),
    .v_sync      (v_sync),
    .v_back      (v_back),
    .delay_cycles(delay_cycles)
  ) uut (
    .clk  (clk),
    .rst_n(rst_n),
    .draw (draw),
    .seed (seed),
    .vga  (vga),
    .busy (busy)
  );

  initial begin
    forever #50 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic pixel_t pattern_color(input pixel_t s, input int x, input int y);
    logic [color_bits-1:0] xl;
    logic [color_bits-1:0] yl;
    logic [color_bits-1:0] sum;
    pixel_t                p;
    xl    = x[color_bits-1:0];
    yl    = y[color_bits-1:0];
    sum   = xl + yl;  // carry dropped.
    p.red = xl ^ s.red;
    p.grn = yl ^ s.grn;
    p.blu = sum ^ s.blu;
    return p;
  endfunction

  function automatic pixel_t random_seed();
    logic [31:0] r;
    r = $urandom;
    return r[$bits(pixel_t)-1:0];
  endfunction

  function automatic stage_t idle_stage();
    stage_t s;
    s    = '0;
    s.hs = 1'b1;
    s.vs = 1'b1;
    return s;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_vga(input vga_out_t exp, input vga_out_t act, input string name);
    if (act !== exp) begin
      stop_run($sformatf("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_bit(input logic exp, input logic act, input string name);
    if (act !== exp) begin
      stop_run($sformatf("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  task automatic check_pixel(input pixel_t exp, input pixel_t act, input string name);
    if (act !== exp) begin
      stop_run($sformatf("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // raster model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) rst_seen <= rst_n;

  always @(negedge clk) begin
    if (!rst_seen) begin
      since_rst = 0;
      en_prev   = 1'b0;
      mh        = 0;
      mv        = 0;
      busy_m    = 1'b0;
      cur       = idle_stage();
      p1        = idle_stage();
      p2        = idle_stage();
    end else begin
      since_rst++;
      en = (since_rst >= delay_cycles);
      if (en_prev) begin  // counting starts one cycle after enable.
        if (mh == h_total - 1) begin
          mh = 0;
          mv = (mv == v_total - 1) ? 0 : mv + 1;
        end else begin
          mh++;
        end
      end
      en_prev = en;
      // drawer gets the port on every non-active cycle.
      if (prev_busy && !prev_act) begin
        wx = writes_m % width;
        wy = writes_m / width;
        model_mem[wy][wx] = pattern_color(seed_m, wx, wy);
        written[wy][wx]   = 1'b1;
        writes_m++;
        if (writes_m == width * height) begin
          busy_m = 1'b0;
        end
      end else if (!prev_busy && prev_draw) begin
        busy_m   = 1'b1;
        writes_m = 0;
        seed_m   = prev_seed;
      end
      cur     = idle_stage();
      cur.act = en && (mh < width) && (mv < height);
      cur.hs  = !((mh >= width + h_front) && (mh < width + h_front + h_sync));
      cur.vs  = !((mv >= height + v_front) && (mv < height + v_front + v_sync));
      if (cur.act && written[mv][mh]) begin
        cur.known = 1'b1;
        cur.pix   = model_mem[mv][mh];
      end
    end
    // pins show the position from two cycles back.
    if (!p2.act) begin
      exp_vga       = '0;
      exp_vga.hsync = p2.hs;
      exp_vga.vsync = p2.vs;
      check_vga(exp_vga, vga, "vga");
    end else begin
      check_bit(p2.hs, vga.hsync, "vga.hsync");
      check_bit(p2.vs, vga.vsync, "vga.vsync");
      if (p2.known) begin
        got_pix.red = vga.red;
        got_pix.grn = vga.grn;
        got_pix.blu = vga.blu;
        check_pixel(p2.pix, got_pix, "vga colour");
      end
    end
    check_bit(busy_m, busy, "busy");
    p2        = p1;
    p1        = cur;
    prev_draw = draw;
    prev_seed = seed;
    prev_act  = cur.act;
    prev_busy = busy_m;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin : watchdog
    cycles = 0;
    @(posedge clk);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    stop_run($sformatf("run did not finish within %0d cycles", limit));
  end

  initial begin
    int gaps [n_draws];
    int gap_total;
    rst_n = 1'b0;
    draw  = 1'b0;
    seed  = '0;
    void'($urandom(91678));
    gap_total = 0;
    foreach (gaps[i]) begin
      gaps[i] = $urandom_range(3, 0);
      gap_total += gaps[i];
    end
    limit = (gap_total + 2 * n_draws + 5) * frame_cycles;  // tail and reset in the slack.
    repeat (4) @(posedge clk);
    #5 rst_n = 1'b1;
    for (int i = 0; i < n_draws; i++) begin
      repeat (gaps[i] * frame_cycles) next_cycle();
      draw = 1'b1;
      seed = random_seed();
      next_cycle();
      draw = 1'b0;
      repeat (2) begin
        repeat ($urandom_range(60, 1)) next_cycle();
        if (busy) begin
          draw = 1'b1;
          seed = random_seed();  // drawer should drop this one.
          next_cycle();
          draw = 1'b0;
        end
      end
      while (busy) next_cycle();
    end
    repeat (2 * frame_cycles) next_cycle();
    $display("All checks passed");
    $finish;
  end

endmodule
